// ==== Makefile ====
SIM := obj_dir/Vtb_wr_demux

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): flist.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_wr_demux -o Vtb_wr_demux -f flist.f

# the log decides pass or fail
run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_wr_demux.sv ====
// Write demux testbench
`include "demux_consts.svh"

module tb_wr_demux;
  timeunit 1ns;
  timeprecision 1ps;

  import axi_chan_pkg::*;
  import demux_pkg::*;

  localparam int NUM_TESTS   = 10;
  localparam int TIMEOUT_CYC = 200 * NUM_TESTS;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                clk = 1'b0;
  logic                rst_n;
  logic                sbr_aw_valid;
  id_t                 sbr_aw_id;
  addr_t               sbr_aw_addr;
  sel_t                sbr_aw_sel;
  logic                sbr_aw_ready;
  logic                sbr_w_valid;
  data_t               sbr_w_data;
  strb_t               sbr_w_strb;
  logic                sbr_w_last;
  logic                sbr_w_ready;
  logic                sbr_b_valid;
  id_t                 sbr_b_id;
  resp_t               sbr_b_resp;
  logic                sbr_b_ready;
  logic [`NUM_MGR-1:0] mgr_aw_valid;
  id_t                 mgr_aw_id;
  addr_t               mgr_aw_addr;
  logic [`NUM_MGR-1:0] mgr_aw_ready;
  logic [`NUM_MGR-1:0] mgr_w_valid;
  data_t               mgr_w_data;
  strb_t               mgr_w_strb;
  logic                mgr_w_last;
  logic [`NUM_MGR-1:0] mgr_w_ready;
  logic [`NUM_MGR-1:0] mgr_b_valid;
  id_t  [`NUM_MGR-1:0] mgr_b_id;
  resp_t [`NUM_MGR-1:0] mgr_b_resp;
  logic [`NUM_MGR-1:0] mgr_b_ready;

  // ------------------------------
  // test table and scoreboard
  // ------------------------------
  string tbl_name  [NUM_TESTS];
  id_t   tbl_id    [NUM_TESTS];
  sel_t  tbl_sel   [NUM_TESTS];
  addr_t tbl_addr  [NUM_TESTS];
  int    tbl_beats [NUM_TESTS];
  data_t tbl_data  [NUM_TESTS];
  // OKAY, EXOKAY, SLVERR per manager port
  resp_t port_code [`NUM_MGR] = '{2'b00, 2'b01, 2'b10};

  // accepted AW ids and finished W bursts per port
  id_t         aw_ids     [`NUM_MGR][$];
  int          w_last_cnt [`NUM_MGR];
  logic        w_done     [NUM_TESTS];
  logic        b_done     [NUM_TESTS];
  logic        ord_seen   [NUM_TESTS];
  int          test_err   [NUM_TESTS];
  int          aw_idx      = 0;
  int          w_idx       = 0;
  int          w_beat      = 0;
  int          b_count     = 0;
  int          err_count   = 0;
  int          check_count = 0;
  logic [31:0] lfsr_q;

  wr_demux_top u_wr_demux_top (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .sbr_aw_valid_i ( sbr_aw_valid ),
    .sbr_aw_id_i    ( sbr_aw_id    ),
    .sbr_aw_addr_i  ( sbr_aw_addr  ),
    .sbr_aw_sel_i   ( sbr_aw_sel   ),
    .sbr_aw_ready_o ( sbr_aw_ready ),
    .sbr_w_valid_i  ( sbr_w_valid  ),
    .sbr_w_data_i   ( sbr_w_data   ),
    .sbr_w_strb_i   ( sbr_w_strb   ),
    .sbr_w_last_i   ( sbr_w_last   ),
    .sbr_w_ready_o  ( sbr_w_ready  ),
    .sbr_b_valid_o  ( sbr_b_valid  ),
    .sbr_b_id_o     ( sbr_b_id     ),
    .sbr_b_resp_o   ( sbr_b_resp   ),
    .sbr_b_ready_i  ( sbr_b_ready  ),
    .mgr_aw_valid_o ( mgr_aw_valid ),
    .mgr_aw_id_o    ( mgr_aw_id    ),
    .mgr_aw_addr_o  ( mgr_aw_addr  ),
    .mgr_aw_ready_i ( mgr_aw_ready ),
    .mgr_w_valid_o  ( mgr_w_valid  ),
    .mgr_w_data_o   ( mgr_w_data   ),
    .mgr_w_strb_o   ( mgr_w_strb   ),
    .mgr_w_last_o   ( mgr_w_last   ),
    .mgr_w_ready_i  ( mgr_w_ready  ),
    .mgr_b_valid_i  ( mgr_b_valid  ),
    .mgr_b_id_i     ( mgr_b_id     ),
    .mgr_b_resp_i   ( mgr_b_resp   ),
    .mgr_b_ready_o  ( mgr_b_ready  )
  );

  always #10 clk = ~clk;

  // galois LFSR stepped once per bit taken
  function automatic logic rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    return b;
  endfunction

  task automatic add_entry(int e, string name, id_t id, sel_t sel, addr_t addr, int beats,
                           data_t data);
    tbl_name[e]  = name;
    tbl_id[e]    = id;
    tbl_sel[e]   = sel;
    tbl_addr[e]  = addr;
    tbl_beats[e] = beats;
    tbl_data[e]  = data;
  endtask

  // ------------------------------
  // error reporting
  // ------------------------------
  task automatic note_error(int e);
    err_count++;
    test_err[e]++;
  endtask

  task automatic report_problem(string msg);
    $display("error: %s", msg);
    err_count++;
  endtask

  task automatic check_aw(int e, id_t exp_id, id_t act_id, addr_t exp_addr, addr_t act_addr,
                          sel_t exp_sel, sel_t act_sel);
    check_count++;
    if (act_id !== exp_id || act_addr !== exp_addr || act_sel !== exp_sel) begin
      $display("[FAIL] %s AW: expected id %h addr %h port %0d, actual id %h addr %h port %0d",
               tbl_name[e], exp_id, exp_addr, exp_sel, act_id, act_addr, act_sel);
      note_error(e);
    end
  endtask

  // values shown as data, strobe, last and port
  task automatic check_w(int e, int beat, data_t exp_data, data_t act_data, strb_t exp_strb,
                         strb_t act_strb, sel_t exp_sel, sel_t act_sel, logic exp_last,
                         logic act_last);
    check_count++;
    if (act_data !== exp_data || act_strb !== exp_strb || act_sel !== exp_sel
        || act_last !== exp_last) begin
      $display("[FAIL] %s W beat %0d: expected %h %h %b p%0d, actual %h %h %b p%0d",
               tbl_name[e], beat, exp_data, exp_strb, exp_last, exp_sel,
               act_data, act_strb, act_last, act_sel);
      note_error(e);
    end
  endtask

  task automatic check_b(int e, id_t exp_id, id_t act_id, resp_t exp_resp, resp_t act_resp);
    check_count++;
    if (act_id !== exp_id || act_resp !== exp_resp) begin
      $display("[FAIL] %s B: expected id %h resp %0d, actual id %h resp %0d",
               tbl_name[e], exp_id, exp_resp, act_id, act_resp);
      note_error(e);
    end
  endtask

  // ------------------------------
  // monitors sample on the rising edge
  // ------------------------------
  // an AW may not show up while an older write with the same low ID bits
  // is still open toward another port
  task automatic check_order(int cur);
    for (int e = 0; e < cur; e++) begin
      if (!b_done[e] && !ord_seen[cur] && tbl_sel[e] != tbl_sel[cur]
          && tbl_id[e][`LOOK_BITS-1:0] == tbl_id[cur][`LOOK_BITS-1:0]) begin
        report_problem($sformatf("%s AW reached port %0d while %s is still open at port %0d",
                                 tbl_name[cur], tbl_sel[cur], tbl_name[e], tbl_sel[e]));
        ord_seen[cur] = 1'b1;
      end
    end
  endtask

  task automatic track_aw();
    int cur;
    cur = aw_idx;
    if (mgr_aw_valid != '0) begin
      if ($countones(mgr_aw_valid) != 1) begin
        report_problem("AW valid raised on more than one manager port");
      end
      if (cur >= NUM_TESTS) begin
        report_problem("AW offered after the last table entry");
      end else begin
        check_order(cur);
      end
    end
    for (int p = 0; p < `NUM_MGR; p++) begin
      if (mgr_aw_valid[p] && mgr_aw_ready[p] && cur < NUM_TESTS) begin
        check_aw(cur, tbl_id[cur], mgr_aw_id, tbl_addr[cur], mgr_aw_addr, tbl_sel[cur],
                 sel_t'(p));
        aw_ids[p].push_back(mgr_aw_id);
        aw_idx++;
      end
    end
  endtask

  // W beats come in table order
  // beat k carries first data plus k
  task automatic track_w();
    data_t exp_data;
    logic  exp_last;
    if ($countones(mgr_w_valid) > 1) begin
      report_problem("W valid raised on more than one manager port");
    end
    for (int p = 0; p < `NUM_MGR; p++) begin
      if (mgr_w_valid[p] && mgr_w_ready[p]) begin
        if (w_idx >= NUM_TESTS) begin
          report_problem("W beat seen after the last burst of the table");
        end else begin
          exp_data = tbl_data[w_idx] + data_t'(w_beat);
          exp_last = (w_beat == tbl_beats[w_idx] - 1);
          check_w(w_idx, w_beat, exp_data, mgr_w_data, '1, mgr_w_strb, tbl_sel[w_idx],
                  sel_t'(p), exp_last, mgr_w_last);
          if (exp_last) begin
            w_last_cnt[p]++;
            w_done[w_idx] = 1'b1;
            w_idx++;
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end
    end
  endtask

  // writes sharing low ID bits get their B in AW order
  task automatic collect_b();
    int hit;
    hit = -1;
    if (sbr_b_valid && sbr_b_ready) begin
      // oldest write with these low ID bits still waiting for its B
      for (int e = 0; e < aw_idx; e++) begin
        if (hit < 0 && !b_done[e]
            && tbl_id[e][`LOOK_BITS-1:0] == sbr_b_id[`LOOK_BITS-1:0]) begin
          hit = e;
        end
      end
      if (hit < 0) begin
        report_problem($sformatf("B with ID %h matches no open write", sbr_b_id));
      end else begin
        if (!w_done[hit]) begin
          report_problem($sformatf("B for %s came before its last W beat", tbl_name[hit]));
        end
        check_b(hit, tbl_id[hit], sbr_b_id, port_code[tbl_sel[hit]], sbr_b_resp);
        b_done[hit] = 1'b1;
        b_count++;
        $display("test %s finished with %0d errors", tbl_name[hit], test_err[hit]);
      end
    end
  endtask

  // ------------------------------
  // manager models and B ready
  // ------------------------------
  initial begin : mgr_model
    logic [`NUM_MGR-1:0] b_taken;
    lfsr_q       = 32'h0e2c_d9dc;
    mgr_aw_ready = '0;
    mgr_w_ready  = '0;
    mgr_b_valid  = '0;
    mgr_b_id     = '0;
    mgr_b_resp   = '0;
    sbr_b_ready  = 1'b0;
    for (int e = 0; e < NUM_TESTS; e++) begin
      w_done[e]   = 1'b0;
      b_done[e]   = 1'b0;
      ord_seen[e] = 1'b0;
      test_err[e] = 0;
    end
    for (int p = 0; p < `NUM_MGR; p++) begin
      w_last_cnt[p] = 0;
    end
    forever begin
      @(posedge clk);
      b_taken = '0;
      if (rst_n) begin
        track_aw();
        track_w();
        b_taken = mgr_b_valid & mgr_b_ready;
        collect_b();
      end
      @(negedge clk);
      for (int p = 0; p < `NUM_MGR; p++) begin
        if (b_taken[p]) begin
          mgr_b_valid[p] = 1'b0;
        end
        // answer once both the AW and the last W beat are in
        if (!mgr_b_valid[p] && aw_ids[p].size() > 0 && w_last_cnt[p] > 0) begin
          mgr_b_valid[p] = 1'b1;
          mgr_b_id[p]    = aw_ids[p].pop_front();
          mgr_b_resp[p]  = port_code[p];
          w_last_cnt[p]--;
        end
        // ready about three cycles in four
        mgr_aw_ready[p] = rand_bit() | rand_bit();
        mgr_w_ready[p]  = rand_bit() | rand_bit();
      end
      sbr_b_ready = rand_bit() | rand_bit();
    end
  end

  // ------------------------------
  // subordinate stimulus
  // ------------------------------
  task automatic drive_aw();
    for (int e = 0; e < NUM_TESTS; e++) begin
      @(negedge clk);
      sbr_aw_valid = 1'b1;
      sbr_aw_id    = tbl_id[e];
      sbr_aw_addr  = tbl_addr[e];
      sbr_aw_sel   = tbl_sel[e];
      @(posedge clk);
      while (!sbr_aw_ready) begin
        @(posedge clk);
      end
    end
    @(negedge clk);
    sbr_aw_valid = 1'b0;
  endtask

  task automatic drive_w();
    for (int e = 0; e < NUM_TESTS; e++) begin
      for (int k = 0; k < tbl_beats[e]; k++) begin
        @(negedge clk);
        sbr_w_valid = 1'b1;
        sbr_w_data  = tbl_data[e] + data_t'(k);
        sbr_w_strb  = '1;
        sbr_w_last  = (k == tbl_beats[e] - 1);
        @(posedge clk);
        while (!sbr_w_ready) begin
          @(posedge clk);
        end
      end
    end
    @(negedge clk);
    sbr_w_valid = 1'b0;
  endtask

  initial begin : main
    rst_n        = 1'b0;
    sbr_aw_valid = 1'b0;
    sbr_aw_id    = '0;
    sbr_aw_addr  = '0;
    sbr_aw_sel   = '0;
    sbr_w_valid  = 1'b0;
    sbr_w_data   = '0;
    sbr_w_strb   = '0;
    sbr_w_last   = 1'b0;
    //        index name          id     sel   addr      beats data
    add_entry(0, "p0_single",   4'h1, 2'd0, 16'h1000, 1, 16'h0100);
    add_entry(1, "p1_burst4",   4'h2, 2'd1, 16'h2000, 4, 16'h0200);
    add_entry(2, "p2_burst2",   4'h3, 2'd2, 16'h3000, 2, 16'h0300);
    add_entry(3, "same_id_p2",  4'h5, 2'd2, 16'h4000, 3, 16'h0400);
    add_entry(4, "p0_burst3",   4'h0, 2'd0, 16'h5000, 3, 16'h0500);
    add_entry(5, "same_id_p1",  4'h9, 2'd1, 16'h6000, 1, 16'h0600);
    add_entry(6, "p1_burst2",   4'h6, 2'd1, 16'h7000, 2, 16'h0700);
    add_entry(7, "order_p2",    4'ha, 2'd2, 16'h8000, 4, 16'h0800);
    add_entry(8, "p0_burst4",   4'h7, 2'd0, 16'h9000, 4, 16'h0900);
    add_entry(9, "p1_single",   4'hf, 2'd1, 16'ha000, 1, 16'h0a00);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // AW and W run on their own
    // W bursts follow AW order
    fork
      drive_aw();
      drive_w();
    join
    wait (b_count == NUM_TESTS);
    repeat (5) @(posedge clk);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // hang guard of 200 cycles per table entry
  initial begin : watchdog
    repeat (TIMEOUT_CYC + 10) @(posedge clk);
    $display("timeout: only %0d of %0d writes got a B response within %0d cycles",
             b_count, NUM_TESTS, TIMEOUT_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/axi_chan_pkg.sv
src/demux_pkg.sv
src/w_router.sv
src/b_rr_arb.sv
src/id_counters.sv
src/aw_route_ctrl.sv
src/wr_demux_top.sv
bench/tb_wr_demux.sv

// ==== src/aw_route_ctrl.sv ====
// AW admission and W select control
`include "demux_consts.svh"

module aw_route_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // subordinate AW handshake
  input  logic                  aw_valid_i,
  input  demux_pkg::sel_t       aw_sel_i,
  output logic                  aw_ready_o,
  // manager AW handshakes
  output logic [`NUM_MGR-1:0]   mgr_aw_valid_o,
  input  logic [`NUM_MGR-1:0]   mgr_aw_ready_i,
  // ID table
  input  demux_pkg::sel_t       look_sel_i,
  input  logic                  look_occupied_i,
  input  logic                  id_full_i,
  output logic                  push_o,
  // W steering
  output demux_pkg::sel_t       w_sel_o,
  output logic                  w_sel_valid_o,
  input  logic                  w_burst_done_i
);
  import demux_pkg::*;

  logic lock_q;
  logic lock_d;
  logic offer;
  logic sel_ready;
  logic admit;
  logic w_open_any;
  cnt_t w_open_q;
  sel_t w_sel_q;

  // ------------------------------
  // admission
  // ------------------------------
  // ready of the port the AW is aimed at
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < `NUM_MGR; i++) begin
      if (aw_sel_i == sel_t'(i)) begin
        sel_ready = mgr_aw_ready_i[i];
      end
    end
  end

  assign w_open_any = (w_open_q != '0);

  // room in both counters, W bursts only toward one port,
  // and no open write with the same low ID bits elsewhere
  assign admit = !id_full_i && (w_open_q != '1)
              && (!w_open_any || (w_sel_q == aw_sel_i))
              && (!look_occupied_i || (look_sel_i == aw_sel_i));

  always_comb begin
    offer  = 1'b0;
    push_o = 1'b0;
    lock_d = lock_q;
    if (lock_q) begin
      // already pushed, only wait for the manager
      offer = 1'b1;
      if (sel_ready) begin
        lock_d = 1'b0;
      end
    end else if (aw_valid_i && admit) begin
      // first offer books the write right away
      offer  = 1'b1;
      push_o = 1'b1;
      lock_d = !sel_ready;
    end
  end

  assign aw_ready_o = offer & sel_ready;

  for (genvar g = 0; g < `NUM_MGR; g++) begin : gen_aw_valid
    assign mgr_aw_valid_o[g] = offer && (aw_sel_i == sel_t'(g));
  end

  // ------------------------------
  // lock and open W bursts
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q   <= 1'b0;
      w_open_q <= '0;
      w_sel_q  <= '0;
    end else begin
      lock_q <= lock_d;
      // push and burst end together leave the count as is
      if (push_o && !w_burst_done_i) begin
        w_open_q <= w_open_q + cnt_t'(1);
      end else if (!push_o && w_burst_done_i) begin
        w_open_q <= w_open_q - cnt_t'(1);
      end
      if (push_o) begin
        w_sel_q <= aw_sel_i;
      end
    end
  end

  // a W beat may ride along with its own AW
  assign w_sel_o       = w_open_any ? w_sel_q : aw_sel_i;
  assign w_sel_valid_o = push_o | w_open_any;

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|mgr_aw_valid_o && !aw_ready_o) |=> $stable(mgr_aw_valid_o))
    else $error("AW valid dropped before the manager took it");

  // the W router may only close bursts that were admitted
  a_w_open_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (w_open_q == '0) |-> !(w_burst_done_i && !push_o))
    else $error("open W burst counter underflow");

endmodule

// ==== src/axi_chan_pkg.sv ====
// AXI write channel field types
`include "demux_consts.svh"

package axi_chan_pkg;

  // ------------------------------
  // AW and B fields
  // ------------------------------
  typedef logic [`ID_W-1:0] id_t;
  typedef logic [`ADDR_W-1:0] addr_t;

  // OKAY 0, EXOKAY 1, SLVERR 2, DECERR 3
  typedef logic [1:0] resp_t;

  // ------------------------------
  // W fields
  // ------------------------------
  typedef logic [`DATA_W-1:0] data_t;
  // one strobe bit per data byte
  typedef logic [`DATA_W/8-1:0] strb_t;

endpackage

// ==== src/b_rr_arb.sv ====
// Round-robin arbiter for B responses
`include "demux_consts.svh"

module b_rr_arb (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // one B channel per manager
  input  logic                [`NUM_MGR-1:0] in_valid_i,
  input  axi_chan_pkg::id_t   [`NUM_MGR-1:0] in_id_i,
  input  axi_chan_pkg::resp_t [`NUM_MGR-1:0] in_resp_i,
  output logic                [`NUM_MGR-1:0] in_ready_o,
  // merged B toward the subordinate
  output logic                               out_valid_o,
  output axi_chan_pkg::id_t                  out_id_o,
  output axi_chan_pkg::resp_t                out_resp_o,
  input  logic                               out_ready_i
);

  logic [`SEL_W-1:0] ptr_q;
  logic              lock_q;
  logic [`SEL_W-1:0] rr_idx;
  logic              rr_found;
  logic [`SEL_W-1:0] gnt_idx;

  // ------------------------------
  // round-robin pick
  // ------------------------------
  always_comb begin
    rr_found = 1'b0;
    rr_idx   = ptr_q;
    // ports above the last winner first
    for (int i = 0; i < `NUM_MGR; i++) begin
      if (!rr_found && in_valid_i[i] && (i > int'(ptr_q))) begin
        rr_found = 1'b1;
        rr_idx   = i[`SEL_W-1:0];
      end
    end
    // then wrap, last winner itself comes last
    for (int i = 0; i < `NUM_MGR; i++) begin
      if (!rr_found && in_valid_i[i] && (i <= int'(ptr_q))) begin
        rr_found = 1'b1;
        rr_idx   = i[`SEL_W-1:0];
      end
    end
  end

  // a stalled winner keeps the grant
  assign gnt_idx     = lock_q ? ptr_q : rr_idx;
  assign out_valid_o = lock_q | rr_found;

  always_comb begin
    out_id_o   = '0;
    out_resp_o = '0;
    in_ready_o = '0;
    for (int i = 0; i < `NUM_MGR; i++) begin
      if (gnt_idx == i[`SEL_W-1:0]) begin
        out_id_o      = in_id_i[i];
        out_resp_o    = in_resp_i[i];
        in_ready_o[i] = out_valid_o & out_ready_i;
      end
    end
  end

  // ------------------------------
  // grant state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= out_valid_o & ~out_ready_i;
      if (out_valid_o) begin
        ptr_q <= gnt_idx;
      end
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_id_o) && $stable(out_resp_o)))
    else $error("B output changed while stalled");

endmodule

// ==== src/demux_consts.svh ====
// Write demux sizing constants
`ifndef DEMUX_CONSTS_SVH
`define DEMUX_CONSTS_SVH

// number of manager ports behind the demux
`define NUM_MGR 3
// bits needed to name one manager port
`define SEL_W 2

// AXI field widths
`define ID_W 4
`define ADDR_W 16
`define DATA_W 16

// low ID bits that share one ordering counter
`define LOOK_BITS 2
// in-flight counters and the open W burst counter
`define CNT_W 3

`endif

// ==== src/demux_pkg.sv ====
// Demux bookkeeping types
`include "demux_consts.svh"

package demux_pkg;

  // index of one manager port
  typedef logic [`SEL_W-1:0] sel_t;

  // low ID bits, one ordering counter each
  typedef logic [`LOOK_BITS-1:0] look_id_t;

  // number of writes still in flight
  // also used for the open W burst count
  typedef logic [`CNT_W-1:0] cnt_t;

endpackage

// ==== src/id_counters.sv ====
// Per-ID in-flight write counters
`include "demux_consts.svh"

module id_counters (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // lookup for the waiting AW
  input  demux_pkg::look_id_t look_id_i,
  output demux_pkg::sel_t     look_sel_o,
  output logic                look_occupied_o,
  output logic                full_o,
  // new write booked
  input  logic                push_i,
  input  demux_pkg::look_id_t push_id_i,
  input  demux_pkg::sel_t     push_sel_i,
  // write retired by its B
  input  logic                pop_i,
  input  demux_pkg::look_id_t pop_id_i
);
  import demux_pkg::*;

  localparam int unsigned NUM_IDS = 1 << `LOOK_BITS;

  cnt_t               cnt_q [NUM_IDS];
  sel_t               sel_q [NUM_IDS];
  logic [NUM_IDS-1:0] push_hit;
  logic [NUM_IDS-1:0] pop_hit;
  logic [NUM_IDS-1:0] at_max;

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      push_hit[i] = push_i && (push_id_i == look_id_t'(i));
      pop_hit[i]  = pop_i && (pop_id_i == look_id_t'(i));
      at_max[i]   = &cnt_q[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        // push and pop on one ID cancel out
        if (push_hit[i] && !pop_hit[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (pop_hit[i] && !push_hit[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // port the open writes of an ID went to
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      sel_q[push_id_i] <= push_sel_i;
    end
  end

  assign look_sel_o      = sel_q[look_id_i];
  assign look_occupied_o = (cnt_q[look_id_i] != '0);
  assign full_o          = |at_max;

  // every B must belong to a booked write
  a_pop_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (cnt_q[pop_id_i] != '0))
    else $error("B response for an ID with no open write");

endmodule

// ==== src/w_router.sv ====
// W channel steering to one manager
`include "demux_consts.svh"

module w_router (
  // subordinate W handshake
  input  logic                w_valid_i,
  input  logic                w_last_i,
  output logic                w_ready_o,
  // target port from AW admission
  input  demux_pkg::sel_t     w_sel_i,
  input  logic                w_sel_valid_i,
  // manager W handshakes
  output logic [`NUM_MGR-1:0] mgr_w_valid_o,
  input  logic [`NUM_MGR-1:0] mgr_w_ready_i,
  // last beat of a burst went through
  output logic                burst_done_o
);
  import demux_pkg::*;

  // only the selected port sees the handshake
  // nothing moves before the AW of the burst is admitted
  always_comb begin
    mgr_w_valid_o = '0;
    w_ready_o     = 1'b0;
    for (int i = 0; i < `NUM_MGR; i++) begin
      if (w_sel_valid_i && (w_sel_i == sel_t'(i))) begin
        mgr_w_valid_o[i] = w_valid_i;
        w_ready_o        = mgr_w_ready_i[i];
      end
    end
  end

  // closes one open burst in the AW controller
  assign burst_done_o = w_valid_i & w_ready_o & w_last_i;

endmodule

// ==== src/wr_demux_top.sv ====
// AXI4 write demux top level
`include "demux_consts.svh"

module wr_demux_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // subordinate AW
  input  logic                               sbr_aw_valid_i,
  input  axi_chan_pkg::id_t                  sbr_aw_id_i,
  input  axi_chan_pkg::addr_t                sbr_aw_addr_i,
  input  demux_pkg::sel_t                    sbr_aw_sel_i,
  output logic                               sbr_aw_ready_o,
  // subordinate W
  input  logic                               sbr_w_valid_i,
  input  axi_chan_pkg::data_t                sbr_w_data_i,
  input  axi_chan_pkg::strb_t                sbr_w_strb_i,
  input  logic                               sbr_w_last_i,
  output logic                               sbr_w_ready_o,
  // subordinate B
  output logic                               sbr_b_valid_o,
  output axi_chan_pkg::id_t                  sbr_b_id_o,
  output axi_chan_pkg::resp_t                sbr_b_resp_o,
  input  logic                               sbr_b_ready_i,
  // manager AW, payload shared by all ports
  output logic                [`NUM_MGR-1:0] mgr_aw_valid_o,
  output axi_chan_pkg::id_t                  mgr_aw_id_o,
  output axi_chan_pkg::addr_t                mgr_aw_addr_o,
  input  logic                [`NUM_MGR-1:0] mgr_aw_ready_i,
  // manager W, payload shared by all ports
  output logic                [`NUM_MGR-1:0] mgr_w_valid_o,
  output axi_chan_pkg::data_t                mgr_w_data_o,
  output axi_chan_pkg::strb_t                mgr_w_strb_o,
  output logic                               mgr_w_last_o,
  input  logic                [`NUM_MGR-1:0] mgr_w_ready_i,
  // manager B
  input  logic                [`NUM_MGR-1:0] mgr_b_valid_i,
  input  axi_chan_pkg::id_t   [`NUM_MGR-1:0] mgr_b_id_i,
  input  axi_chan_pkg::resp_t [`NUM_MGR-1:0] mgr_b_resp_i,
  output logic                [`NUM_MGR-1:0] mgr_b_ready_o
);
  import demux_pkg::*;

  // ID table lookup and update
  look_id_t aw_look_id;
  look_id_t b_look_id;
  sel_t     look_sel;
  logic     look_occupied;
  logic     id_full;
  logic     push;
  logic     b_pop;
  // W steering
  sel_t     w_sel;
  logic     w_sel_valid;
  logic     w_burst_done;

  assign aw_look_id = sbr_aw_id_i[`LOOK_BITS-1:0];
  assign b_look_id  = sbr_b_id_o[`LOOK_BITS-1:0];
  // a write retires when its B leaves on the subordinate side
  assign b_pop      = sbr_b_valid_o & sbr_b_ready_i;

  // AW and W payloads go to every port, valid picks the target
  assign mgr_aw_id_o   = sbr_aw_id_i;
  assign mgr_aw_addr_o = sbr_aw_addr_i;
  assign mgr_w_data_o  = sbr_w_data_i;
  assign mgr_w_strb_o  = sbr_w_strb_i;
  assign mgr_w_last_o  = sbr_w_last_i;

  aw_route_ctrl u_aw_route_ctrl (
    .clk_i           ( clk_i          ),
    .rst_n_i         ( rst_n_i        ),
    .aw_valid_i      ( sbr_aw_valid_i ),
    .aw_sel_i        ( sbr_aw_sel_i   ),
    .aw_ready_o      ( sbr_aw_ready_o ),
    .mgr_aw_valid_o  ( mgr_aw_valid_o ),
    .mgr_aw_ready_i  ( mgr_aw_ready_i ),
    .look_sel_i      ( look_sel       ),
    .look_occupied_i ( look_occupied  ),
    .id_full_i       ( id_full        ),
    .push_o          ( push           ),
    .w_sel_o         ( w_sel          ),
    .w_sel_valid_o   ( w_sel_valid    ),
    .w_burst_done_i  ( w_burst_done   )
  );

  id_counters u_id_counters (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .look_id_i       ( aw_look_id    ),
    .look_sel_o      ( look_sel      ),
    .look_occupied_o ( look_occupied ),
    .full_o          ( id_full       ),
    .push_i          ( push          ),
    .push_id_i       ( aw_look_id    ),
    .push_sel_i      ( sbr_aw_sel_i  ),
    .pop_i           ( b_pop         ),
    .pop_id_i        ( b_look_id     )
  );

  w_router u_w_router (
    .w_valid_i     ( sbr_w_valid_i ),
    .w_last_i      ( sbr_w_last_i  ),
    .w_ready_o     ( sbr_w_ready_o ),
    .w_sel_i       ( w_sel         ),
    .w_sel_valid_i ( w_sel_valid   ),
    .mgr_w_valid_o ( mgr_w_valid_o ),
    .mgr_w_ready_i ( mgr_w_ready_i ),
    .burst_done_o  ( w_burst_done  )
  );

  b_rr_arb u_b_rr_arb (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .in_valid_i  ( mgr_b_valid_i ),
    .in_id_i     ( mgr_b_id_i    ),
    .in_resp_i   ( mgr_b_resp_i  ),
    .in_ready_o  ( mgr_b_ready_o ),
    .out_valid_o ( sbr_b_valid_o ),
    .out_id_o    ( sbr_b_id_o    ),
    .out_resp_o  ( sbr_b_resp_o  ),
    .out_ready_i ( sbr_b_ready_i )
  );

endmodule
